//--- rv_core.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_hazard.sv
hdl/rv_execute.sv
hdl/rv_mem_stage.sv
hdl/rv_core.sv
tests/wb_mem_model.sv
tests/tb_rv_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timescale 1ns/100ps --top-module tb_rv_core \
    -f rv_core.f -o sim_rv_core > build.log 2>&1; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_rv_core > sim.log 2>&1; then
  cat sim.log
  echo "Simulation did not exit cleanly"
  exit 1
fi

cat sim.log
if grep -qx "TEST PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tests/tb_rv_core.sv
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pipe_pkg::*;

  localparam logic [31:0] SEED         = 32'h78dafc62;
  localparam int          RETIRE_LIMIT = 500;
  localparam int          IMEM_WORDS   = 64;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [`RV_XLEN-1:0] imem_data;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  retire_t             retire;

  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [29:0] prog_len;

  // Program being built and the retire stream it should produce
  logic [31:0] prog_q [$];
  logic [31:0] exp_pc [$];
  logic        exp_we [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];

  int errors;
  int checks;

  rv_core i_rv_core (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .wb_req(wb_req), .wb_rsp(wb_rsp), .retire(retire)
  );

  wb_mem_model #(.SEED(SEED)) i_wb_mem (
    .clk(clk), .rst(rst), .req(wb_req), .rsp(wb_rsp)
  );

  always #10 clk = ~clk;

  // Same-cycle instruction port with NOPs past the program
  always_comb begin
    if (imem_addr[31:2] < prog_len) begin
      imem_data = imem[imem_addr[7:2]];
    end else begin
      imem_data = `RV_NOP;
    end
  end

  // ==============================
  // Instruction encoding
  // ==============================

  function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] addi_op(input logic [4:0] rd, input logic [4:0] rs1,
      input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] rr_op(input logic [6:0] f7, input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lw_op(input logic [4:0] rd, input logic [4:0] rs1,
      input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw_op(input logic [4:0] rs2, input logic [4:0] rs1,
      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_op(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] slt_rule(input logic [31:0] a, input logic [31:0] b);
    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  endfunction

  // ==============================
  // Program and expectation helpers
  // ==============================

  function automatic logic [31:0] next_pc();
    return 32'(prog_q.size()) << 2;
  endfunction

  task automatic new_program();
    prog_q.delete();
    exp_pc.delete();
    exp_we.delete();
    exp_rd.delete();
    exp_val.delete();
  endtask

  task automatic retiring(input logic [31:0] instr, input logic we, input logic [4:0] rd,
      input logic [31:0] val);
    exp_pc.push_back(next_pc());
    exp_we.push_back(we);
    exp_rd.push_back(rd);
    exp_val.push_back(val);
    prog_q.push_back(instr);
  endtask

  // Wrong-path word that never retires
  task automatic squashed(input logic [31:0] instr);
    prog_q.push_back(instr);
  endtask

  function automatic void compare(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endfunction

  task automatic load_and_reset();
    @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog_q.size()) ? prog_q[i] : `RV_NOP;
    end
    prog_len = 30'(prog_q.size());
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic collect_retires();
    int got;
    int cycles;
    got = 0;
    cycles = 0;
    while (got < exp_pc.size() && cycles < RETIRE_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (retire.valid) begin
        compare("retire.pc", exp_pc[got], retire.pc);
        compare("retire.we", 32'(exp_we[got]), 32'(retire.we));
        if (exp_we[got]) begin
          compare("retire.rd", 32'(exp_rd[got]), 32'(retire.rd));
          compare("retire.wdata", exp_val[got], retire.wdata);
        end
        got++;
      end
    end
    if (got < exp_pc.size()) begin
      errors++;
      $display("Timeout at %0t: only %0d of %0d instructions retired", $time, got,
               exp_pc.size());
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================

  task automatic reset_state_test();
    new_program();
    load_and_reset();
    @(negedge clk);
    compare("retire.valid", 32'd0, 32'(retire.valid));
    compare("wb_req.cyc", 32'd0, 32'(wb_req.cyc));
    compare("wb_req.stb", 32'd0, 32'(wb_req.stb));
    compare("imem_addr", `RV_RESET_PC, imem_addr);
  endtask

  // Each result feeds the next so operands come from MEM and WB
  task automatic alu_chain_test();
    logic [31:0] r [0:31];
    new_program();
    r[1] = 32'h1234_5000;
    retiring(lui_op(5'd1, 20'h12345), 1'b1, 5'd1, r[1]);
    r[2] = r[1] + 32'h0000_0678;
    retiring(addi_op(5'd2, 5'd1, 12'h678), 1'b1, 5'd2, r[2]);
    r[3] = r[2] + r[1];
    retiring(rr_op(7'b0000000, 3'b000, 5'd3, 5'd2, 5'd1), 1'b1, 5'd3, r[3]);
    r[4] = r[3] - r[2];
    retiring(rr_op(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd2), 1'b1, 5'd4, r[4]);
    r[5] = r[4] & r[3];
    retiring(rr_op(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd3), 1'b1, 5'd5, r[5]);
    r[6] = r[5] | r[2];
    retiring(rr_op(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd2), 1'b1, 5'd6, r[6]);
    r[7] = r[6] ^ r[4];
    retiring(rr_op(7'b0000000, 3'b100, 5'd7, 5'd6, 5'd4), 1'b1, 5'd7, r[7]);
    r[8] = slt_rule(r[7], r[3]);
    retiring(rr_op(7'b0000000, 3'b010, 5'd8, 5'd7, 5'd3), 1'b1, 5'd8, r[8]);
    // Negative immediate then a signed compare
    r[9] = r[8] + 32'hFFFF_FFFB;
    retiring(addi_op(5'd9, 5'd8, 12'hFFB), 1'b1, 5'd9, r[9]);
    r[10] = slt_rule(r[9], r[8]);
    retiring(rr_op(7'b0000000, 3'b010, 5'd10, 5'd9, 5'd8), 1'b1, 5'd10, r[10]);
    load_and_reset();
    collect_retires();
  endtask

  task automatic store_load_test();
    logic [31:0] r [0:31];
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    new_program();
    r[1] = 32'hCAFE_1000;
    retiring(lui_op(5'd1, 20'hCAFE1), 1'b1, 5'd1, r[1]);
    r[1] = r[1] + 32'h0000_0234;
    retiring(addi_op(5'd1, 5'd1, 12'h234), 1'b1, 5'd1, r[1]);
    r[2] = 32'h0000_0040;
    retiring(addi_op(5'd2, 5'd0, 12'h040), 1'b1, 5'd2, r[2]);
    addr_a = r[2] + 32'd8;
    retiring(sw_op(5'd1, 5'd2, 12'h008), 1'b0, 5'd0, 32'd0);
    r[3] = r[1];
    retiring(lw_op(5'd3, 5'd2, 12'h008), 1'b1, 5'd3, r[3]);
    // Load-use on rs1
    r[4] = r[3] + r[1];
    retiring(rr_op(7'b0000000, 3'b000, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, r[4]);
    r[5] = r[4] + 32'd1;
    retiring(addi_op(5'd5, 5'd4, 12'h001), 1'b1, 5'd5, r[5]);
    addr_b = r[2] - 32'd4;
    retiring(sw_op(5'd4, 5'd2, 12'hFFC), 1'b0, 5'd0, 32'd0);
    r[6] = r[4];
    retiring(lw_op(5'd6, 5'd2, 12'hFFC), 1'b1, 5'd6, r[6]);
    // Load-use on rs2
    r[7] = r[5] - r[6];
    retiring(rr_op(7'b0100000, 3'b000, 5'd7, 5'd5, 5'd6), 1'b1, 5'd7, r[7]);
    load_and_reset();
    collect_retires();
    compare("memory word at first store", r[1], i_wb_mem.mem[addr_a[9:2]]);
    compare("memory word at second store", r[4], i_wb_mem.mem[addr_b[9:2]]);
  endtask

  // Layout puts each target at pc plus offset
  task automatic branch_test();
    logic [31:0] r [0:31];
    logic [31:0] link;
    new_program();
    r[1] = 32'd7;
    retiring(addi_op(5'd1, 5'd0, 12'd7), 1'b1, 5'd1, r[1]);
    r[2] = 32'd7;
    retiring(addi_op(5'd2, 5'd0, 12'd7), 1'b1, 5'd2, r[2]);
    // Taken BEQ skips two words
    retiring(branch_op(3'b000, 5'd1, 5'd2, 13'd12), 1'b0, 5'd0, 32'd0);
    squashed(addi_op(5'd9, 5'd0, 12'h111));
    squashed(addi_op(5'd9, 5'd0, 12'h222));
    // Not-taken BNE whose target is a squashed word
    retiring(branch_op(3'b001, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0);
    link = next_pc() + 32'd4;
    retiring(jal_op(5'd3, 21'd12), 1'b1, 5'd3, link);
    squashed(addi_op(5'd9, 5'd0, 12'h333));
    squashed(addi_op(5'd9, 5'd0, 12'h444));
    r[4] = link + r[1];
    retiring(rr_op(7'b0000000, 3'b000, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, r[4]);
    retiring(addi_op(5'd0, 5'd0, 12'h000), 1'b0, 5'd0, 32'd0);
    load_and_reset();
    collect_retires();
  endtask

  task automatic x0_write_test();
    logic [31:0] r [0:31];
    new_program();
    retiring(addi_op(5'd0, 5'd0, 12'h055), 1'b0, 5'd0, 32'd0);
    retiring(lui_op(5'd0, 20'hABCDE), 1'b0, 5'd0, 32'd0);
    r[1] = 32'h0000_0021;
    retiring(addi_op(5'd1, 5'd0, 12'h021), 1'b1, 5'd1, r[1]);
    r[2] = r[1];
    retiring(rr_op(7'b0000000, 3'b000, 5'd2, 5'd1, 5'd0), 1'b1, 5'd2, r[2]);
    // x0 target right before an x0 source
    retiring(rr_op(7'b0000000, 3'b000, 5'd0, 5'd1, 5'd1), 1'b0, 5'd0, 32'd0);
    r[3] = r[1];
    retiring(rr_op(7'b0000000, 3'b000, 5'd3, 5'd0, 5'd1), 1'b1, 5'd3, r[3]);
    load_and_reset();
    collect_retires();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    prog_len = '0;
    errors = 0;
    checks = 0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = `RV_NOP;
    end

    reset_state_test();
    alu_chain_test();
    store_load_test();
    branch_test();
    x0_write_test();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/wb_mem_model.sv
`default_nettype none

module wb_mem_model #(
  parameter logic [31:0] SEED = 32'h0000_0001
) (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_pipe_pkg::wb_req_t req,
  output rv_pipe_pkg::wb_rsp_t rsp
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WORDS = 256;

  logic [31:0] mem [0:WORDS-1];
  logic [31:0] rng;
  logic [1:0]  wait_left;
  logic        active;
  logic [7:0]  word;

  assign word = req.adr[9:2];

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    rng <= SEED;
    // Each word starts as a function of its byte address
    for (int i = 0; i < WORDS; i++) begin
      mem[i] <= 32'hA5C3_0000 | 32'(i * 4);
    end
  end

  // ==============================
  // Classic slave with one word per transfer
  // ==============================

  // Extra 0 to 3 wait states on top of the registered ack
  always @(posedge clk) begin
    if (rst) begin
      rsp.ack   <= 1'b0;
      rsp.dat_r <= '0;
      active    <= 1'b0;
    end else if (rsp.ack) begin
      rsp.ack <= 1'b0;
      active  <= 1'b0;
    end else if (req.cyc && req.stb) begin
      if (!active) begin
        active    <= 1'b1;
        rng       <= xorshift(rng);
        wait_left <= rng[1:0];
      end else if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        rsp.ack   <= 1'b1;
        rsp.dat_r <= mem[word];
        if (req.we) begin
          mem[word] <= req.dat_w;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none

`include "rv_params.svh"

module rv_core (
  input  logic                 clk,
  input  logic                 rst,
  output logic [`RV_XLEN-1:0]  imem_addr,
  input  logic [`RV_XLEN-1:0]  imem_data,
  output rv_pipe_pkg::wb_req_t wb_req,
  input  rv_pipe_pkg::wb_rsp_t wb_rsp,
  output rv_pipe_pkg::retire_t retire
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  // Stall and redirect
  logic                load_use;
  logic                mem_busy;
  logic                redirect_valid;
  logic [`RV_XLEN-1:0] redirect_pc;

  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;

  // Decode-stage register reads
  reg_idx_t            rs1_idx;
  reg_idx_t            rs2_idx;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;

  rv_fetch i_fetch (
    .clk(clk), .rst(rst), .load_use(load_use), .mem_busy(mem_busy),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .imem_addr(imem_addr), .imem_data(imem_data), .if_id(if_id)
  );

  rv_decode i_decode (
    .clk(clk), .rst(rst), .load_use(load_use), .mem_busy(mem_busy),
    .redirect_valid(redirect_valid), .if_id(if_id),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .id_ex(id_ex)
  );

  rv_regfile i_regfile (
    .clk(clk), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .wb(mem_wb)
  );

  rv_hazard i_hazard (
    .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .load_use(load_use)
  );

  rv_execute i_execute (
    .clk(clk), .rst(rst), .mem_busy(mem_busy), .id_ex(id_ex),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_fwd(ex_mem.result), .wb_fwd(mem_wb.wdata),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .ex_mem(ex_mem)
  );

  rv_mem_stage i_mem_stage (
    .clk(clk), .rst(rst), .ex_mem(ex_mem), .wb_req(wb_req), .wb_rsp(wb_rsp),
    .mem_busy(mem_busy), .mem_wb(mem_wb), .retire(retire)
  );

endmodule

`default_nettype wire

//--- hdl/rv_mem_stage.sv
`default_nettype none

`include "rv_params.svh"

module rv_mem_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_pipe_pkg::ex_mem_t ex_mem,
  output rv_pipe_pkg::wb_req_t wb_req,
  input  rv_pipe_pkg::wb_rsp_t wb_rsp,
  output logic                 mem_busy,
  output rv_pipe_pkg::mem_wb_t mem_wb,
  output rv_pipe_pkg::retire_t retire
);

  logic mem_op;
  logic ack_q;

  assign mem_op = ex_mem.valid && (ex_mem.load || ex_mem.store);

  // ==============================
  // Wishbone classic master
  // ==============================

  // One idle cycle after every ack
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_req.cyc && wb_rsp.ack;
    end
  end

  always_comb begin
    wb_req.cyc   = mem_op && !ack_q;
    wb_req.stb   = mem_op && !ack_q;
    wb_req.we    = ex_mem.store;
    wb_req.adr   = ex_mem.result;
    wb_req.dat_w = ex_mem.store_data;
  end

  assign mem_busy = mem_op && !wb_rsp.ack;

  // ==============================
  // MEM/WB register and retire
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb.valid <= 1'b0;
    end else if (mem_busy) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.pc        <= ex_mem.pc;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.wdata     <= ex_mem.load ? wb_rsp.dat_r : ex_mem.result;
    end
  end

  // x0 targets report no write
  always_comb begin
    retire.valid = mem_wb.valid;
    retire.pc    = mem_wb.pc;
    retire.rd    = mem_wb.rd;
    retire.we    = mem_wb.reg_write && (mem_wb.rd != '0);
    retire.wdata = mem_wb.wdata;
  end

endmodule

`default_nettype wire

//--- hdl/rv_execute.sv
`default_nettype none

`include "rv_params.svh"

module rv_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_busy,
  input  rv_pipe_pkg::id_ex_t   id_ex,
  input  rv_pipe_pkg::fwd_sel_e fwd_a,
  input  rv_pipe_pkg::fwd_sel_e fwd_b,
  input  logic [`RV_XLEN-1:0]   mem_fwd,
  input  logic [`RV_XLEN-1:0]   wb_fwd,
  output logic                  redirect_valid,
  output logic [`RV_XLEN-1:0]   redirect_pc,
  output rv_pipe_pkg::ex_mem_t  ex_mem
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [`RV_XLEN-1:0] fwd_a_val, fwd_b_val;
  logic [`RV_XLEN-1:0] rs_a, rs_b;
  logic [`RV_XLEN-1:0] op_a, op_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic [`RV_XLEN-1:0] link_pc;
  logic                taken;
  logic                keep_valid;
  logic [`RV_XLEN-1:0] keep_a, keep_b;

  function automatic logic [`RV_XLEN-1:0] fwd_value(input fwd_sel_e sel,
      input logic [`RV_XLEN-1:0] reg_val, input logic [`RV_XLEN-1:0] mem_val,
      input logic [`RV_XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign fwd_a_val = fwd_value(fwd_a, id_ex.rs1_val, mem_fwd, wb_fwd);
  assign fwd_b_val = fwd_value(fwd_b, id_ex.rs2_val, mem_fwd, wb_fwd);

  // ==============================
  // Operand freeze during stall
  // ==============================

  // Write-back drains to a bubble while the memory stage waits,
  // so forwarded operands are captured on the first stalled cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      keep_valid <= 1'b0;
    end else begin
      keep_valid <= mem_busy;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_busy && !keep_valid) begin
      keep_a <= fwd_a_val;
      keep_b <= fwd_b_val;
    end
  end

  assign rs_a = keep_valid ? keep_a : fwd_a_val;
  assign rs_b = keep_valid ? keep_b : fwd_b_val;

  // ==============================
  // ALU and branch
  // ==============================

  assign op_a    = id_ex.ctrl.a_pc ? id_ex.pc : rs_a;
  assign op_b    = id_ex.ctrl.b_imm ? id_ex.imm : rs_b;
  assign link_pc = id_ex.pc + `RV_XLEN'(4);

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB:    alu_y = op_a - op_b;
      ALU_AND:    alu_y = op_a & op_b;
      ALU_OR:     alu_y = op_a | op_b;
      ALU_XOR:    alu_y = op_a ^ op_b;
      ALU_SLT:    alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_y = op_b;
      default:    alu_y = op_a + op_b;
    endcase
  end

  always_comb begin
    case (id_ex.ctrl.branch)
      BR_BEQ:  taken = (rs_a == rs_b);
      BR_BNE:  taken = (rs_a != rs_b);
      BR_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Target is PC plus immediate from the ALU
  assign redirect_valid = id_ex.valid && taken && !mem_busy;
  assign redirect_pc    = alu_y;

  // ==============================
  // EX/MEM register
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem.valid <= 1'b0;
    end else if (!mem_busy) begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.pc         <= id_ex.pc;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.load       <= id_ex.ctrl.load;
      ex_mem.store      <= id_ex.ctrl.store;
      ex_mem.result     <= (id_ex.ctrl.branch == BR_JAL) ? link_pc : alu_y;
      ex_mem.store_data <= rs_b;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_hazard.sv
`default_nettype none

module rv_hazard (
  input  rv_pipe_pkg::id_ex_t   id_ex,
  input  rv_pipe_pkg::ex_mem_t  ex_mem,
  input  rv_pipe_pkg::mem_wb_t  mem_wb,
  input  rv_isa_pkg::reg_idx_t  rs1_idx,
  input  rv_isa_pkg::reg_idx_t  rs2_idx,
  output rv_pipe_pkg::fwd_sel_e fwd_a,
  output rv_pipe_pkg::fwd_sel_e fwd_b,
  output logic                  load_use
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // Youngest matching producer wins
  function automatic fwd_sel_e pick_src(input logic used, input reg_idx_t src);
    fwd_sel_e sel;
    sel = FWD_RF;
    if (used && (src != '0)) begin
      // Load data is not ready in the memory stage
      if (ex_mem.valid && ex_mem.reg_write && !ex_mem.load && (ex_mem.rd == src)) begin
        sel = FWD_MEM;
      end else if (mem_wb.valid && mem_wb.reg_write && (mem_wb.rd == src)) begin
        sel = FWD_WB;
      end
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick_src(id_ex.ctrl.use_rs1, id_ex.rs1_idx);
    fwd_b = pick_src(id_ex.ctrl.use_rs2, id_ex.rs2_idx);
  end

  // Load in execute feeding the instruction in decode
  always_comb begin
    load_use = id_ex.valid && id_ex.ctrl.load && (id_ex.rd != '0) &&
               ((id_ex.rd == rs1_idx) || (id_ex.rd == rs2_idx));
  end

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`default_nettype none

`include "rv_params.svh"

module rv_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load_use,
  input  logic                 mem_busy,
  input  logic                 redirect_valid,
  input  rv_pipe_pkg::if_id_t  if_id,
  output rv_isa_pkg::reg_idx_t rs1_idx,
  output rv_isa_pkg::reg_idx_t rs2_idx,
  input  logic [`RV_XLEN-1:0]  rs1_data,
  input  logic [`RV_XLEN-1:0]  rs2_data,
  output rv_pipe_pkg::id_ex_t  id_ex
);
  import rv_isa_pkg::*;

  logic [`RV_XLEN-1:0] instr;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  ctrl_t               ctrl;
  logic [`RV_XLEN-1:0] imm;

  assign instr   = if_id.instr;
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  // ==============================
  // Control and immediate
  // ==============================

  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (opcode_e'(instr[6:0]))
      OP_LUI: begin
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.b_imm     = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = {instr[31:12], 12'b0};
      end
      OP_OP_IMM: begin
        imm = {{20{instr[31]}}, instr[31:20]};
        // ADDI only
        if (funct3 == 3'b000) begin
          ctrl.use_rs1   = 1'b1;
          ctrl.b_imm     = 1'b1;
          ctrl.reg_write = 1'b1;
        end
      end
      OP_OP: begin
        ctrl.use_rs1   = 1'b1;
        ctrl.use_rs2   = 1'b1;
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = ALU_ADD;
          10'b0100000_000: ctrl.alu_op = ALU_SUB;
          10'b0000000_111: ctrl.alu_op = ALU_AND;
          10'b0000000_110: ctrl.alu_op = ALU_OR;
          10'b0000000_100: ctrl.alu_op = ALU_XOR;
          10'b0000000_010: ctrl.alu_op = ALU_SLT;
          default:         ctrl        = '0;
        endcase
      end
      OP_LOAD: begin
        imm = {{20{instr[31]}}, instr[31:20]};
        // Word access only
        if (funct3 == 3'b010) begin
          ctrl.use_rs1   = 1'b1;
          ctrl.b_imm     = 1'b1;
          ctrl.load      = 1'b1;
          ctrl.reg_write = 1'b1;
        end
      end
      OP_STORE: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        if (funct3 == 3'b010) begin
          ctrl.use_rs1 = 1'b1;
          ctrl.use_rs2 = 1'b1;
          ctrl.b_imm   = 1'b1;
          ctrl.store   = 1'b1;
        end
      end
      OP_BRANCH: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          ctrl.branch  = (funct3 == 3'b000) ? BR_BEQ : BR_BNE;
          ctrl.use_rs1 = 1'b1;
          ctrl.use_rs2 = 1'b1;
          ctrl.a_pc    = 1'b1;
          ctrl.b_imm   = 1'b1;
        end
      end
      OP_JAL: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        ctrl.branch    = BR_JAL;
        ctrl.a_pc      = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

  // ==============================
  // ID/EX register
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.valid <= 1'b0;
    end else if (!mem_busy) begin
      if (load_use || redirect_valid) begin
        id_ex.valid <= 1'b0;
      end else begin
        id_ex.valid   <= if_id.valid;
        id_ex.pc      <= if_id.pc;
        id_ex.ctrl    <= ctrl;
        id_ex.rs1_idx <= rs1_idx;
        id_ex.rs2_idx <= rs2_idx;
        id_ex.rd      <= instr[11:7];
        id_ex.rs1_val <= rs1_data;
        id_ex.rs2_val <= rs2_data;
        id_ex.imm     <= imm;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
`default_nettype none

`include "rv_params.svh"

module rv_regfile (
  input  logic                 clk,
  input  rv_isa_pkg::reg_idx_t rs1_idx,
  input  rv_isa_pkg::reg_idx_t rs2_idx,
  output logic [`RV_XLEN-1:0]  rs1_data,
  output logic [`RV_XLEN-1:0]  rs2_data,
  input  rv_pipe_pkg::mem_wb_t wb
);
  import rv_isa_pkg::*;

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];
  logic                wr_en;

  assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wb.rd] <= wb.wdata;
    end
  end

  // Same-cycle write is visible to decode
  function automatic logic [`RV_XLEN-1:0] read_reg(input reg_idx_t idx);
    if (idx == '0) return '0;
    if (wr_en && (wb.rd == idx)) return wb.wdata;
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_reg(rs1_idx);
    rs2_data = read_reg(rs2_idx);
  end

endmodule

`default_nettype wire

//--- hdl/rv_fetch.sv
`default_nettype none

`include "rv_params.svh"

module rv_fetch (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load_use,
  input  logic                 mem_busy,
  input  logic                 redirect_valid,
  input  logic [`RV_XLEN-1:0]  redirect_pc,
  output logic [`RV_XLEN-1:0]  imem_addr,
  input  logic [`RV_XLEN-1:0]  imem_data,
  output rv_pipe_pkg::if_id_t  if_id
);

  logic [`RV_XLEN-1:0] pc;

  // Instruction port answers in the same cycle
  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= `RV_RESET_PC;
      if_id.valid <= 1'b0;
    end else if (!mem_busy) begin
      if (redirect_valid) begin
        // Word being fetched is on the wrong path
        pc          <= redirect_pc;
        if_id.valid <= 1'b0;
        if_id.pc    <= pc;
        if_id.instr <= `RV_NOP;
      end else if (!load_use) begin
        pc          <= pc + `RV_XLEN'(4);
        if_id.valid <= 1'b1;
        if_id.pc    <= pc;
        if_id.instr <= imem_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_pipe_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pipe_pkg;

  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  // ==============================
  // Stage registers
  // ==============================

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                 valid;
    logic [`RV_XLEN-1:0]  pc;
    rv_isa_pkg::ctrl_t    ctrl;
    rv_isa_pkg::reg_idx_t rs1_idx;
    rv_isa_pkg::reg_idx_t rs2_idx;
    rv_isa_pkg::reg_idx_t rd;
    logic [`RV_XLEN-1:0]  rs1_val;
    logic [`RV_XLEN-1:0]  rs2_val;
    logic [`RV_XLEN-1:0]  imm;
  } id_ex_t;

  typedef struct packed {
    logic                 valid;
    logic [`RV_XLEN-1:0]  pc;
    rv_isa_pkg::reg_idx_t rd;
    logic                 reg_write;
    logic                 load;
    logic                 store;
    logic [`RV_XLEN-1:0]  result;
    logic [`RV_XLEN-1:0]  store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                 valid;
    logic [`RV_XLEN-1:0]  pc;
    rv_isa_pkg::reg_idx_t rd;
    logic                 reg_write;
    logic [`RV_XLEN-1:0]  wdata;
  } mem_wb_t;

  // ==============================
  // Wishbone classic and retire
  // ==============================

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [`RV_XLEN-1:0] adr;
    logic [`RV_XLEN-1:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [`RV_XLEN-1:0] dat_r;
  } wb_rsp_t;

  typedef struct packed {
    logic                 valid;
    logic [`RV_XLEN-1:0]  pc;
    rv_isa_pkg::reg_idx_t rd;
    logic                 we;
    logic [`RV_XLEN-1:0]  wdata;
  } retire_t;

endpackage

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_isa_pkg;

  typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_OP_IMM = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_JAL
  } branch_e;

  // All-zero value is a harmless no-op
  typedef struct packed {
    alu_op_e alu_op;
    branch_e branch;
    logic    use_rs1;
    logic    use_rs2;
    logic    a_pc;
    logic    b_imm;
    logic    load;
    logic    store;
    logic    reg_write;
  } ctrl_t;

endpackage

`default_nettype wire

//--- hdl/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data and address width
`define RV_XLEN 32
// Architectural registers including x0
`define RV_REG_COUNT 32
`define RV_RESET_PC 32'h0000_0000
// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif
